// ==== logic/avmem_defs.svh ====
// Avalon memory shim widths, burst limits and default register stage counts

`ifndef AVMEM_DEFS_SVH
`define AVMEM_DEFS_SVH

// ==============================
// Bus widths
// ==============================

// Word address, one word per data beat
`define AVMEM_ADDR_W        26

// Data bus width in bits. Byte enables follow as one bit per byte
`define AVMEM_DATA_W        64

// ==============================
// Burst limits
// ==============================

// The AFU counter reaches 64, so it needs 7 bits
`define AVMEM_AFU_BCNT_W    7

// The FIU counter reaches 8, so it needs 4 bits
`define AVMEM_FIU_BCNT_W    4

// Largest burst the FIU side accepts in one command
`define AVMEM_FIU_MAX_BURST 8

// Default depth of each timing pipe, at the AFU edge and at the FIU edge
`define AVMEM_REG_STAGES    2

`endif

// ==== logic/avmem_pkg.sv ====
// Avalon memory shim package with the bus field types and the AFU and FIU command structs

`include "avmem_defs.svh"

package avmem_pkg;

    // ==============================
    // Field types
    // ==============================

    typedef logic [`AVMEM_ADDR_W-1:0]     avmem_addr_t;
    typedef logic [`AVMEM_DATA_W-1:0]     avmem_data_t;
    typedef logic [`AVMEM_DATA_W/8-1:0]   avmem_be_t;
    typedef logic [`AVMEM_AFU_BCNT_W-1:0] avmem_afu_bcnt_t;
    typedef logic [`AVMEM_FIU_BCNT_W-1:0] avmem_fiu_bcnt_t;

    // ==============================
    // Command structs
    // ==============================

    // One command or write beat as the AFU sees it, with the wide burst count
    typedef struct packed {
        logic            read;
        logic            write;
        avmem_addr_t     address;
        avmem_afu_bcnt_t burstcount;
        avmem_data_t     writedata;
        avmem_be_t       byteenable;
    } avmem_afu_cmd_t;

    // Same command after splitting, so the count never exceeds the FIU limit
    typedef struct packed {
        logic            read;
        logic            write;
        avmem_addr_t     address;
        avmem_fiu_bcnt_t burstcount;
        avmem_data_t     writedata;
        avmem_be_t       byteenable;
    } avmem_fiu_cmd_t;

endpackage

// ==== logic/avmem_reg_pipe.sv ====
// Avalon command register pipeline with skid buffers so waitrequest is registered at each stage

`timescale 1ns/1ps

`include "avmem_defs.svh"

module avmem_reg_pipe
#(
    parameter type T        = avmem_pkg::avmem_fiu_cmd_t,
    parameter int  N_STAGES = `AVMEM_REG_STAGES
)
(
    input  logic afu_clk,
    input  logic rst_n,

    input  logic in_valid,
    input  T     in_cmd,
    output logic in_waitrequest,

    output logic out_valid,
    output T     out_cmd,
    input  logic out_waitrequest
);

    // Element s is the boundary in front of stage s. The last element is the output
    logic valid_c [N_STAGES+1];
    logic wait_c  [N_STAGES+1];
    T     cmd_c   [N_STAGES+1];

    assign valid_c[0]       = in_valid;
    assign cmd_c[0]         = in_cmd;
    assign in_waitrequest   = wait_c[0];

    assign out_valid        = valid_c[N_STAGES];
    assign out_cmd          = cmd_c[N_STAGES];
    assign wait_c[N_STAGES] = out_waitrequest;

    // With no stages the loop is empty and the boundaries above join directly
    for (genvar s = 0; s < N_STAGES; s++)
    begin : g_stage
        logic main_valid;
        logic skid_valid;
        logic wait_q;
        T     main_cmd;
        T     skid_cmd;
        logic up_fire;
        logic down_fire;

        // Upstream transfers only against the registered waitrequest
        assign up_fire   = valid_c[s] & ~wait_q;
        assign down_fire = main_valid & ~wait_c[s+1];

        // ==============================
        // Slot control
        // ==============================

        always_ff @(posedge afu_clk or negedge rst_n)
        begin
            if (!rst_n)
            begin
                main_valid <= 1'b0;
                skid_valid <= 1'b0;
                // Upstream is stalled until the first clock out of reset
                wait_q     <= 1'b1;
            end
            else if (down_fire || !main_valid)
            begin
                // Main slot drains or is empty, so the skid entry moves up first
                main_valid <= skid_valid | up_fire;
                skid_valid <= 1'b0;
                wait_q     <= 1'b0;
            end
            else if (up_fire)
            begin
                // Main slot is stuck, so the new item parks in the skid slot
                skid_valid <= 1'b1;
                wait_q     <= 1'b1;
            end
            else
            begin
                wait_q <= skid_valid;
            end
        end

        // ==============================
        // Payload slots
        // ==============================

        // Payload slots load under the same conditions as their valid bits
        always_ff @(posedge afu_clk)
        begin
            if (down_fire || !main_valid)
            begin
                // The skid entry is older than anything arriving now
                main_cmd <= skid_valid ? skid_cmd : cmd_c[s];
            end
            if (up_fire && main_valid && !down_fire)
            begin
                skid_cmd <= cmd_c[s];
            end
        end

        assign valid_c[s+1] = main_valid;
        assign cmd_c[s+1]   = main_cmd;
        assign wait_c[s]    = wait_q;
    end

endmodule

// ==== logic/avmem_burst_mapper.sv ====
// Avalon burst mapper that splits AFU bursts of up to 64 beats into FIU bursts of at most 8

`timescale 1ns/1ps

`include "avmem_defs.svh"

module avmem_burst_mapper
(
    input  logic                       afu_clk,
    input  logic                       rst_n,

    input  logic                       in_valid,
    input  avmem_pkg::avmem_afu_cmd_t  in_cmd,
    output logic                       in_waitrequest,

    output logic                       out_valid,
    output avmem_pkg::avmem_fiu_cmd_t  out_cmd,
    input  logic                       out_waitrequest
);

    import avmem_pkg::*;

    // The FIU limit in both counter widths and as the chunk address step
    localparam avmem_afu_bcnt_t MAX_AFU = `AVMEM_FIU_MAX_BURST;
    localparam avmem_fiu_bcnt_t MAX_FIU = `AVMEM_FIU_MAX_BURST;
    localparam avmem_addr_t     STEP    = `AVMEM_FIU_MAX_BURST;

    // ==============================
    // Burst state
    // ==============================

    // Set while a read is being re-issued or a write burst still has beats to come
    logic            burst_q;
    // Beats left in the AFU burst, counting the one presented now
    avmem_afu_bcnt_t rem_q;
    // Start address of the next FIU chunk
    avmem_addr_t     addr_q;
    // Write beats still owed to the current FIU chunk after the one in flight
    avmem_fiu_bcnt_t chunk_left_q;

    avmem_addr_t     base_addr;
    avmem_afu_bcnt_t base_rem;
    avmem_fiu_bcnt_t chunk_cnt;
    logic            rd_last;
    logic            wr_chunk_start;
    logic            out_fire;

    // On the first beat the AFU command is the source, after that the saved state is
    assign base_addr = burst_q ? addr_q : in_cmd.address;
    assign base_rem  = burst_q ? rem_q  : in_cmd.burstcount;

    // Each chunk is the full FIU burst except for the tail of the AFU burst
    assign chunk_cnt = (base_rem > MAX_AFU) ? MAX_FIU
                                            : base_rem[`AVMEM_FIU_BCNT_W-1:0];

    // A read with no more than one FIU burst left finishes with this issue
    assign rd_last = (base_rem <= MAX_AFU);

    // Writes restart the FIU burst every eighth beat
    assign wr_chunk_start = !burst_q || (chunk_left_q == '0);

    // ==============================
    // Forward path
    // ==============================

    // Nothing is buffered here, so the first chunk leaves in the cycle it arrives
    assign out_valid = in_valid;
    assign out_fire  = out_valid & ~out_waitrequest;

    always_comb
    begin
        out_cmd.read       = in_cmd.read;
        out_cmd.write      = in_cmd.write;
        out_cmd.address    = base_addr;
        out_cmd.burstcount = chunk_cnt;
        out_cmd.writedata  = in_cmd.writedata;
        out_cmd.byteenable = in_cmd.byteenable;
    end

    // A long read stays stalled upstream until its final chunk goes out
    assign in_waitrequest = out_waitrequest | (in_valid & in_cmd.read & ~rd_last);

    // ==============================
    // State update
    // ==============================

    always_ff @(posedge afu_clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            burst_q      <= 1'b0;
            rem_q        <= '0;
            chunk_left_q <= '0;
        end
        else if (out_fire)
        begin
            if (in_cmd.read)
            begin
                // Another chunk follows unless this one covered the rest
                burst_q <= ~rd_last;
                rem_q   <= base_rem - MAX_AFU;
            end
            else
            begin
                // One write beat per transfer and the burst ends with its last beat
                burst_q <= (base_rem > 1);
                rem_q   <= base_rem - 1'b1;
                if (wr_chunk_start)
                begin
                    chunk_left_q <= chunk_cnt - 1'b1;
                end
                else
                begin
                    chunk_left_q <= chunk_left_q - 1'b1;
                end
            end
        end
    end

    // The next chunk address only moves when a new FIU burst is started
    always_ff @(posedge afu_clk)
    begin
        if (out_fire && (in_cmd.read || wr_chunk_start))
        begin
            addr_q <= base_addr + STEP;
        end
    end

endmodule

// ==== logic/avmem_afu_shim.sv ====
// AFU-side Avalon memory shim with timing pipes at both edges and FIU burst splitting

`timescale 1ns/1ps

`include "avmem_defs.svh"

module avmem_afu_shim
#(
    parameter int AFU_REG_STAGES = `AVMEM_REG_STAGES,
    parameter int FIU_REG_STAGES = `AVMEM_REG_STAGES
)
(
    input  logic                       afu_clk,
    input  logic                       rst_n,

    // AFU side where this shim is the slave
    input  logic                       afu_read,
    input  logic                       afu_write,
    input  avmem_pkg::avmem_addr_t     afu_address,
    input  avmem_pkg::avmem_afu_bcnt_t afu_burstcount,
    input  avmem_pkg::avmem_data_t     afu_writedata,
    input  avmem_pkg::avmem_be_t       afu_byteenable,
    output logic                       afu_waitrequest,
    output avmem_pkg::avmem_data_t     afu_readdata,
    output logic                       afu_readdatavalid,

    // FIU side where this shim is the master
    output logic                       fiu_read,
    output logic                       fiu_write,
    output avmem_pkg::avmem_addr_t     fiu_address,
    output avmem_pkg::avmem_fiu_bcnt_t fiu_burstcount,
    output avmem_pkg::avmem_data_t     fiu_writedata,
    output avmem_pkg::avmem_be_t       fiu_byteenable,
    input  logic                       fiu_waitrequest,
    input  avmem_pkg::avmem_data_t     fiu_readdata,
    input  logic                       fiu_readdatavalid
);

    import avmem_pkg::*;

    // ==============================
    // Command path
    // ==============================

    // AFU bus gathered into one struct
    avmem_afu_cmd_t afu_cmd;
    logic           afu_valid;

    // Between the AFU pipe and the mapper
    avmem_afu_cmd_t pipe_cmd;
    logic           pipe_valid;
    logic           pipe_wait;

    // Between the mapper and the FIU pipe
    avmem_fiu_cmd_t map_cmd;
    logic           map_valid;
    logic           map_wait;

    // FIU pipe output before it is spread back onto the bus
    avmem_fiu_cmd_t fiu_cmd;
    logic           fiu_valid;

    assign afu_valid = afu_read | afu_write;

    always_comb
    begin
        afu_cmd.read       = afu_read;
        afu_cmd.write      = afu_write;
        afu_cmd.address    = afu_address;
        afu_cmd.burstcount = afu_burstcount;
        afu_cmd.writedata  = afu_writedata;
        afu_cmd.byteenable = afu_byteenable;
    end

    // Registered stall toward the AFU that stays high through reset
    avmem_reg_pipe
    #(
        .T        (avmem_afu_cmd_t),
        .N_STAGES (AFU_REG_STAGES)
    )
    i_afu_pipe
    (
        .afu_clk         (afu_clk),
        .rst_n           (rst_n),
        .in_valid        (afu_valid),
        .in_cmd          (afu_cmd),
        .in_waitrequest  (afu_waitrequest),
        .out_valid       (pipe_valid),
        .out_cmd         (pipe_cmd),
        .out_waitrequest (pipe_wait)
    );

    avmem_burst_mapper i_mapper
    (
        .afu_clk         (afu_clk),
        .rst_n           (rst_n),
        .in_valid        (pipe_valid),
        .in_cmd          (pipe_cmd),
        .in_waitrequest  (pipe_wait),
        .out_valid       (map_valid),
        .out_cmd         (map_cmd),
        .out_waitrequest (map_wait)
    );

    // Narrow-count payload from here on
    avmem_reg_pipe
    #(
        .T        (avmem_fiu_cmd_t),
        .N_STAGES (FIU_REG_STAGES)
    )
    i_fiu_pipe
    (
        .afu_clk         (afu_clk),
        .rst_n           (rst_n),
        .in_valid        (map_valid),
        .in_cmd          (map_cmd),
        .in_waitrequest  (map_wait),
        .out_valid       (fiu_valid),
        .out_cmd         (fiu_cmd),
        .out_waitrequest (fiu_waitrequest)
    );

    // Only a held pipe entry may raise read or write on the FIU bus
    assign fiu_read       = fiu_valid & fiu_cmd.read;
    assign fiu_write      = fiu_valid & fiu_cmd.write;
    assign fiu_address    = fiu_cmd.address;
    assign fiu_burstcount = fiu_cmd.burstcount;
    assign fiu_writedata  = fiu_cmd.writedata;
    assign fiu_byteenable = fiu_cmd.byteenable;

    // ==============================
    // Response path
    // ==============================

    // Avalon read data cannot be stalled and chunks return in issue order,
    // so beats go straight back to the AFU in the same cycle
    assign afu_readdata      = fiu_readdata;
    assign afu_readdatavalid = fiu_readdatavalid;

endmodule

// ==== test/avmem_tb_mem.sv ====
// FIU-side memory model with random stalls, in-order read returns and FIU command checking

`timescale 1ns/1ps

`include "avmem_defs.svh"

module avmem_tb_mem
(
    input  logic                       afu_clk,
    input  logic                       rst_n,
    // AFU side is only watched, to build the list of expected FIU commands
    input  logic                       afu_read,
    input  logic                       afu_write,
    input  avmem_pkg::avmem_addr_t     afu_address,
    input  avmem_pkg::avmem_afu_bcnt_t afu_burstcount,
    input  logic                       afu_waitrequest,
    input  logic                       fiu_read,
    input  logic                       fiu_write,
    input  avmem_pkg::avmem_addr_t     fiu_address,
    input  avmem_pkg::avmem_fiu_bcnt_t fiu_burstcount,
    input  avmem_pkg::avmem_data_t     fiu_writedata,
    input  avmem_pkg::avmem_be_t       fiu_byteenable,
    output logic                       fiu_waitrequest,
    output avmem_pkg::avmem_data_t     fiu_readdata,
    output logic                       fiu_readdatavalid,
    output logic                       exp_empty,
    output logic                       err
);

    import avmem_pkg::*;

    localparam int WIN_WORDS = 4096;

    // One FIU command as the split rules predict it
    typedef struct packed {
        logic            rd;
        avmem_addr_t     addr;
        avmem_fiu_bcnt_t cnt;
    } fiu_exp_t;

    fiu_exp_t    exp_q [$];
    avmem_data_t mem [WIN_WORDS];
    avmem_data_t rsp_data_q [$];
    int          rsp_due_q [$];
    int          cyc;
    int          last_due;
    int          lat;
    int          due;
    int          afu_wr_left;
    int          fiu_wr_left;
    avmem_addr_t wr_addr;

    // Unwritten words read back as a mix of their own address
    function automatic avmem_data_t pattern_word(input avmem_addr_t a);
        return {6'h2a, a, 6'h15, a};
    endfunction

    // Cut one AFU burst into FIU chunks of at most 8 beats at 8-word steps
    function automatic void fiu_split_ref(input avmem_addr_t addr, input int beats,
                                          input logic rd);
        int       left;
        fiu_exp_t e;
        left   = beats;
        e.rd   = rd;
        e.addr = addr;
        while (left > 0)
        begin
            e.cnt = (left > `AVMEM_FIU_MAX_BURST) ? `AVMEM_FIU_MAX_BURST : left;
            exp_q.push_back(e);
            e.addr = e.addr + `AVMEM_FIU_MAX_BURST;
            left   = left - `AVMEM_FIU_MAX_BURST;
        end
    endfunction

    // Compare a new FIU read or write chunk with the head of the expected list
    task automatic check_command();
        fiu_exp_t e;
        assert (fiu_wr_left == 0)
        else
        begin
            $display("FIU read issued in the middle of a write burst");
            err = 1'b1;
        end
        assert (exp_q.size() != 0)
        else
        begin
            $display("FIU command at address %h arrived with none expected", fiu_address);
            err = 1'b1;
        end
        if (exp_q.size() != 0)
        begin
            e = exp_q.pop_front();
            assert (e === {fiu_read, fiu_address, fiu_burstcount})
            else
            begin
                $display("[ERROR] fiu_read fiu_address fiu_burstcount: expected %h %h %h, got %h %h %h",
                         e.rd, e.addr, e.cnt, fiu_read, fiu_address, fiu_burstcount);
                err = 1'b1;
            end
        end
    endtask

    initial
    begin
        fiu_waitrequest   = 1'b0;
        fiu_readdata      = '0;
        fiu_readdatavalid = 1'b0;
        exp_empty         = 1'b1;
        err               = 1'b0;
        cyc               = 0;
        last_due          = 0;
        afu_wr_left       = 0;
        fiu_wr_left       = 0;
        for (int a = 0; a < WIN_WORDS; a++)
        begin
            mem[a] = pattern_word(a);
        end
    end

    // ==============================
    // Command side
    // ==============================

    always @(posedge afu_clk)
    begin
        if (rst_n)
        begin
            cyc = cyc + 1;
            // A read or the first beat of a write burst starts an AFU command
            if ((afu_read || afu_write) && !afu_waitrequest)
            begin
                if (afu_read || afu_wr_left == 0)
                begin
                    fiu_split_ref(afu_address, afu_burstcount, afu_read);
                end
                if (afu_write)
                begin
                    afu_wr_left = (afu_wr_left == 0) ? int'(afu_burstcount) - 1
                                                     : afu_wr_left - 1;
                end
            end
            if ((fiu_read || fiu_write) && !fiu_waitrequest)
            begin
                if (fiu_read || fiu_wr_left == 0)
                begin
                    check_command();
                end
                if (fiu_write)
                begin
                    if (fiu_wr_left == 0)
                    begin
                        wr_addr     = fiu_address;
                        fiu_wr_left = fiu_burstcount;
                    end
                    for (int b = 0; b < `AVMEM_DATA_W/8; b++)
                    begin
                        if (fiu_byteenable[b])
                        begin
                            mem[int'(wr_addr) % WIN_WORDS][8*b +: 8] = fiu_writedata[8*b +: 8];
                        end
                    end
                    wr_addr     = wr_addr + 1'b1;
                    fiu_wr_left = fiu_wr_left - 1;
                end
                else
                begin
                    // Data is taken now, so later writes cannot leak into this read
                    lat = 2 + $urandom % 5;
                    for (int i = 0; i < fiu_burstcount; i++)
                    begin
                        due = cyc + lat + i;
                        if (due <= last_due)
                        begin
                            due = last_due + 1;
                        end
                        last_due = due;
                        rsp_data_q.push_back(mem[(int'(fiu_address) + i) % WIN_WORDS]);
                        rsp_due_q.push_back(due);
                    end
                end
            end
            exp_empty = (exp_q.size() == 0);
        end
    end

    // ==============================
    // Stall and response side
    // ==============================

    always @(negedge afu_clk)
    begin
        fiu_waitrequest   = (($urandom % 100) < 30);
        fiu_readdatavalid = 1'b0;
        if (rsp_due_q.size() != 0 && rsp_due_q[0] <= cyc)
        begin
            fiu_readdatavalid = 1'b1;
            fiu_readdata      = rsp_data_q.pop_front();
            rsp_due_q.delete(0);
        end
    end

endmodule

// ==== test/avmem_shim_tb.sv ====
// Testbench for the AFU Avalon memory shim with a shadow memory and read data compare

`timescale 1ns/1ps

`include "avmem_defs.svh"

module avmem_shim_tb;

    import avmem_pkg::*;

    localparam int WIN_WORDS = 4096;
    localparam int N_RANDOM  = 200;

    logic            afu_clk;
    logic            rst_n;
    logic            afu_read;
    logic            afu_write;
    avmem_addr_t     afu_address;
    avmem_afu_bcnt_t afu_burstcount;
    avmem_data_t     afu_writedata;
    avmem_be_t       afu_byteenable;
    logic            afu_waitrequest;
    avmem_data_t     afu_readdata;
    logic            afu_readdatavalid;
    logic            fiu_read;
    logic            fiu_write;
    avmem_addr_t     fiu_address;
    avmem_fiu_bcnt_t fiu_burstcount;
    avmem_data_t     fiu_writedata;
    avmem_be_t       fiu_byteenable;
    logic            fiu_waitrequest;
    avmem_data_t     fiu_readdata;
    logic            fiu_readdatavalid;
    logic            mem_exp_empty;
    logic            mem_err;

    // Shadow of the memory window and the read beats the AFU still owes us
    avmem_data_t     shadow [WIN_WORDS];
    avmem_data_t     exp_rd_q [$];
    avmem_data_t     exp_word;
    avmem_addr_t     single_addr [16];
    int              beats_issued;

    avmem_afu_shim i_dut (.*);

    avmem_tb_mem i_mem (.*, .exp_empty(mem_exp_empty), .err(mem_err));

    initial
    begin
        afu_clk = 1'b0;
        forever #4 afu_clk = ~afu_clk;
    end

    task automatic fail_run();
        $display("CHECKS FAILED");
        $fatal(1, "Simulation stopped at the first error");
    endtask

    // ==============================
    // Reference model
    // ==============================

    // Must match the fill of the memory model so untouched words are predictable
    function automatic avmem_data_t pattern_word(input avmem_addr_t a);
        return {6'h2a, a, 6'h15, a};
    endfunction

    function automatic avmem_data_t merge_bytes(input avmem_data_t old_word,
                                                input avmem_data_t new_word,
                                                input avmem_be_t be);
        avmem_data_t w;
        w = old_word;
        for (int b = 0; b < `AVMEM_DATA_W/8; b++)
        begin
            if (be[b])
            begin
                w[8*b +: 8] = new_word[8*b +: 8];
            end
        end
        return w;
    endfunction

    function automatic avmem_data_t expected_read(input int a);
        return shadow[a];
    endfunction

    // ==============================
    // AFU stimulus
    // ==============================

    task automatic send_beat(input logic rd, input avmem_addr_t addr, input int beats,
                             input avmem_data_t data, input avmem_be_t be);
        @(negedge afu_clk);
        afu_read       = rd;
        afu_write      = !rd;
        afu_address    = addr;
        afu_burstcount = avmem_afu_bcnt_t'(beats);
        afu_writedata  = data;
        afu_byteenable = be;
        do
            @(posedge afu_clk);
        while (afu_waitrequest);
    endtask

    task automatic idle_cycles(input int n);
        @(negedge afu_clk);
        afu_read  = 1'b0;
        afu_write = 1'b0;
        repeat (n) @(negedge afu_clk);
    endtask

    task automatic write_burst(input avmem_addr_t addr, input int beats);
        avmem_data_t data;
        avmem_be_t   be;
        beats_issued += beats;
        for (int i = 0; i < beats; i++)
        begin
            data = {$urandom, $urandom};
            be   = ($urandom % 2) ? '1 : avmem_be_t'($urandom);
            shadow[int'(addr) + i] = merge_bytes(shadow[int'(addr) + i], data, be);
            send_beat(1'b0, addr, beats, data, be);
        end
    endtask

    task automatic read_burst(input avmem_addr_t addr, input int beats);
        beats_issued += beats;
        for (int i = 0; i < beats; i++)
        begin
            exp_rd_q.push_back(expected_read(int'(addr) + i));
        end
        send_beat(1'b1, addr, beats, '0, '0);
    endtask

    // ==============================
    // Response compare and watchdog
    // ==============================

    always @(posedge afu_clk)
    begin
        if (rst_n && afu_readdatavalid)
        begin
            assert (exp_rd_q.size() != 0)
            else
            begin
                $display("Read data reached the AFU with no read outstanding");
                fail_run();
            end
            exp_word = exp_rd_q.pop_front();
            assert (afu_readdata === exp_word)
            else
            begin
                $display("[ERROR] afu_readdata: expected %h, got %h", exp_word, afu_readdata);
                fail_run();
            end
        end
    end

    always @(posedge mem_err)
    begin
        fail_run();
    end

    initial
    begin : watchdog
        int cycles;
        cycles = 0;
        while (cycles < 200 + 40 * beats_issued)
        begin
            @(posedge afu_clk);
            cycles++;
        end
        $display("Timeout after %0d cycles with traffic still pending", cycles);
        fail_run();
    end

    initial
    begin : stimulus
        int seed;
        seed           = $urandom(34);
        rst_n          = 1'b0;
        afu_read       = 1'b0;
        afu_write      = 1'b0;
        afu_address    = '0;
        afu_burstcount = '0;
        afu_writedata  = '0;
        afu_byteenable = '0;
        beats_issued   = 0;
        for (int i = 0; i < WIN_WORDS; i++)
        begin
            shadow[i] = pattern_word(i);
        end
        repeat (3) @(posedge afu_clk);
        assert (afu_waitrequest === 1'b1)
        else
        begin
            $display("[ERROR] afu_waitrequest: expected 1, got %h", afu_waitrequest);
            fail_run();
        end
        @(negedge afu_clk);
        rst_n = 1'b1;
        assert ({fiu_read, fiu_write, afu_readdatavalid} === 3'b000)
        else
        begin
            $display("[ERROR] fiu_read fiu_write afu_readdatavalid: expected 0 0 0, got %h %h %h",
                     fiu_read, fiu_write, afu_readdatavalid);
            fail_run();
        end
        // Single beats with mixed byte enables, then read them all back
        for (int i = 0; i < 16; i++)
        begin
            single_addr[i] = $urandom % WIN_WORDS;
            write_burst(single_addr[i], 1);
            idle_cycles($urandom % 3);
        end
        for (int i = 0; i < 16; i++)
        begin
            read_burst(single_addr[i], 1);
            idle_cycles($urandom % 3);
        end
        // Long reads and writes that need splitting, then short ones that must not split
        read_burst(100, 20);
        read_burst(300, 64);
        write_burst(1000, 37);
        idle_cycles(1);
        read_burst(1000, 37);
        write_burst(2000, 8);
        read_burst(2000, 8);
        write_burst(2100, 3);
        read_burst(2100, 5);
        idle_cycles(2);
        // Random mix with idle gaps against the random FIU stalls
        for (int i = 0; i < N_RANDOM; i++)
        begin
            if ($urandom % 2)
            begin
                read_burst($urandom % (WIN_WORDS - 64), 1 + $urandom % 64);
            end
            else
            begin
                write_burst($urandom % (WIN_WORDS - 64), 1 + $urandom % 64);
            end
            idle_cycles($urandom % 4);
        end
        while (exp_rd_q.size() != 0 || !mem_exp_empty)
        begin
            @(posedge afu_clk);
        end
        // Extra FIU traffic would show up in this quiet window
        repeat (20) @(posedge afu_clk);
        if (exp_rd_q.size() == 0 && mem_exp_empty && !mem_err)
        begin
            $display("ALL CHECKS PASSED");
        end
        else
        begin
            $display("Commands or read beats were left over at the end of the run");
            fail_run();
        end
        $finish;
    end

endmodule

// ==== verilog.f ====
+incdir+logic
logic/avmem_pkg.sv
logic/avmem_reg_pipe.sv
logic/avmem_burst_mapper.sv
logic/avmem_afu_shim.sv
test/avmem_tb_mem.sv
test/avmem_shim_tb.sv

// ==== Bender.yml ====
package:
  name: avmem_afu_shim

export_include_dirs:
  - logic

sources:
  - include_dirs:
      - logic
    files:
      - logic/avmem_pkg.sv
      - logic/avmem_reg_pipe.sv
      - logic/avmem_burst_mapper.sv
      - logic/avmem_afu_shim.sv
  - target: test
    include_dirs:
      - logic
    files:
      - test/avmem_tb_mem.sv
      - test/avmem_shim_tb.sv
